// File: design/mips_cfg.svh
// ================================================
// MIPS memory stage configuration
// data memory geometry and load/store opcodes
// ================================================
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data memory size in 32-bit words
`define MEM_DEPTH_WORDS 64
// word index width, log2 of the depth
`define MEM_ADDR_BITS 6

// I-type load opcodes
`define OP_LB  6'h20
`define OP_LH  6'h21
`define OP_LW  6'h23
`define OP_LBU 6'h24
`define OP_LHU 6'h25
// I-type store opcodes
`define OP_SB  6'h28
`define OP_SH  6'h29
`define OP_SW  6'h2B

`endif

// File: design/mipsPkg.sv
// ================================================
// MIPS shared types
// instruction word views and memory operations
// ================================================
package mipsPkg;

    // register-format field layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // immediate-format field layout
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    // one 32-bit word, two readings
    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    // decoded data-memory operation
    typedef enum logic [3:0] {
        memNone,
        memLb,
        memLbu,
        memLh,
        memLhu,
        memLw,
        memSb,
        memSh,
        memSw
    } memOp;

endpackage

// File: design/memOpDecoder.sv
// ================================================
// Memory operation decoder
// maps the opcode to a load/store operation
// ================================================
`timescale 1ns/100ps
`include "mips_cfg.svh"

module memOpDecoder (
    input  mipsPkg::instrWord instr,
    output mipsPkg::memOp     op,
    output logic              isLoad
);
    import mipsPkg::*;

    // opcode lookup, I-type view
    always_comb begin
        case (instr.i.opcode)
            `OP_LB:  op = memLb;
            `OP_LBU: op = memLbu;
            `OP_LH:  op = memLh;
            `OP_LHU: op = memLhu;
            `OP_LW:  op = memLw;
            `OP_SB:  op = memSb;
            `OP_SH:  op = memSh;
            `OP_SW:  op = memSw;
            // alu, branch and the rest
            default: op = memNone;
        endcase
    end

    // loads pick memory data at write-back
    always_comb begin
        case (op)
            memLb,
            memLbu,
            memLh,
            memLhu,
            memLw:   isLoad = 1'b1;
            default: isLoad = 1'b0;
        endcase
    end

endmodule

// File: design/storeAligner.sv
// ================================================
// Store aligner
// forwards write-back data into the store value
// and spreads it over four byte lanes
// ================================================
`timescale 1ns/100ps
`include "mips_cfg.svh"

module storeAligner (
    input  mipsPkg::instrWord          instr,
    input  mipsPkg::memOp              op,
    input  logic [31:0]                addr,
    input  logic [31:0]                storeData,
    input  logic [4:0]                 regAddrWb,
    input  logic [31:0]                regDataWb,
    input  logic                       clr,
    output logic [3:0]                 laneWe,
    output logic [3:0][7:0]            laneData,
    output logic [`MEM_ADDR_BITS-1:0]  wordIndex
);
    import mipsPkg::*;

    logic [31:0] storeValue;
    logic        fwdHit;

    // rt read through the register-format view
    // $zero is never forwarded
    assign fwdHit     = (regAddrWb == instr.r.rt) && (regAddrWb != 5'd0);
    assign storeValue = fwdHit ? regDataWb : storeData;

    // replicate by access size
    // byte and half land on every matching lane
    always_comb begin
        case (op)
            memSb:   laneData = {4{storeValue[7:0]}};
            memSh:   laneData = {2{storeValue[15:0]}};
            default: laneData = storeValue;
        endcase
    end

    // lane enables, lane 0 is the low byte
    always_comb begin
        laneWe = 4'b0000;
        case (op)
            memSw:   laneWe = 4'b1111;
            memSh:   laneWe = addr[1] ? 4'b1100 : 4'b0011;
            memSb:   laneWe = 4'b0001 << addr[1:0];
            default: laneWe = 4'b0000;
        endcase
        // flushed store leaves memory alone
        if (clr) begin
            laneWe = 4'b0000;
        end
    end

    // word index above the byte offset
    assign wordIndex = addr[`MEM_ADDR_BITS+1:2];

endmodule

// File: design/byteBank.sv
// ================================================
// Byte bank
// one byte lane of data memory, sync write,
// async read, cleared on reset
// ================================================
`timescale 1ns/100ps
`include "mips_cfg.svh"

module byteBank (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we,
    input  logic [`MEM_ADDR_BITS-1:0]  index,
    input  logic [7:0]                 d,
    output logic [7:0]                 q
);

    logic [7:0] mem [`MEM_DEPTH_WORDS];

    // write port, whole lane zeroed on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `MEM_DEPTH_WORDS; w++) begin
                mem[w] <= 8'h00;
            end
        end else if (we) begin
            mem[index] <= d;
        end
    end

    // read sees old data during a same-cycle write
    assign q = mem[index];

endmodule

// File: design/loadExtractor.sv
// ================================================
// Load extractor
// picks the byte or half out of the lane word
// and sign or zero extends it
// ================================================
`timescale 1ns/100ps

module loadExtractor (
    input  mipsPkg::memOp   op,
    input  logic [1:0]      byteSel,
    input  logic [3:0][7:0] laneQ,
    output logic [31:0]     loadData
);
    import mipsPkg::*;

    logic [31:0] word;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    // lane 3 ends up in the top byte
    assign word = laneQ;

    // byte by offset, half by addr bit 1
    assign loadByte = laneQ[byteSel];
    assign loadHalf = byteSel[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (op)
            // signed byte
            memLb:   loadData = {{24{loadByte[7]}}, loadByte};
            memLbu:  loadData = {24'h000000, loadByte};
            // signed half
            memLh:   loadData = {{16{loadHalf[15]}}, loadHalf};
            memLhu:  loadData = {16'h0000, loadHalf};
            // lw and everything else, full word
            default: loadData = word;
        endcase
    end

endmodule

// File: design/memStage.sv
// ================================================
// MIPS memory-access stage
// store forwarding and alignment, four byte banks,
// load extension and the MEM/WB pipeline register
// ================================================
`timescale 1ns/100ps
`include "mips_cfg.svh"

module memStage (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        clr,
    input  logic [31:0] instrMem,
    input  logic [31:0] pcMem,
    input  logic [31:0] aluOutMem,
    input  logic [31:0] memWriteDataMem,
    input  logic [4:0]  regWriteAddrMem,
    input  logic [31:0] regWriteDataMem,
    input  logic [4:0]  regAddrWb,
    input  logic [31:0] regDataWb,
    output logic [31:0] instrWb,
    output logic [31:0] pcWb,
    output logic [31:0] memReadDataWb,
    output logic [4:0]  regWriteAddrWb,
    output logic [31:0] regWriteDataWb
);
    import mipsPkg::*;

    memOp                       op;
    logic                       isLoad;
    logic [3:0]                 laneWe;
    logic [3:0][7:0]            laneData;
    logic [3:0][7:0]            laneQ;
    logic [`MEM_ADDR_BITS-1:0]  wordIndex;
    logic [31:0]                loadData;
    logic [31:0]                regWriteData;

    memOpDecoder decoder (
        .instr  (instrMem),
        .op     (op),
        .isLoad (isLoad)
    );

    storeAligner aligner (
        .instr     (instrMem),
        .op        (op),
        .addr      (aluOutMem),
        .storeData (memWriteDataMem),
        .regAddrWb (regAddrWb),
        .regDataWb (regDataWb),
        .clr       (clr),
        .laneWe    (laneWe),
        .laneData  (laneData),
        .wordIndex (wordIndex)
    );

    // four byte lanes share one word index
    for (genvar lane = 0; lane < 4; lane++) begin : genBank
        byteBank bank (
            .clk   (clk),
            .rst   (rst),
            .we    (laneWe[lane]),
            .index (wordIndex),
            .d     (laneData[lane]),
            .q     (laneQ[lane])
        );
    end

    loadExtractor extractor (
        .op       (op),
        .byteSel  (aluOutMem[1:0]),
        .laneQ    (laneQ),
        .loadData (loadData)
    );

    // loads write memory data, others keep the alu result
    assign regWriteData = isLoad ? loadData : regWriteDataMem;

    // MEM/WB register, clear beats stall
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            instrWb        <= '0;
            pcWb           <= '0;
            memReadDataWb  <= '0;
            regWriteAddrWb <= '0;
            regWriteDataWb <= '0;
        end else if (!stall) begin
            instrWb        <= instrMem;
            pcWb           <= pcMem;
            memReadDataWb  <= loadData;
            regWriteAddrWb <= regWriteAddrMem;
            regWriteDataWb <= regWriteData;
        end
    end

endmodule

// File: tb/memStage_assertions.sv
// ================================================
// MEM stage assertions
// WB clear and stall hold, lane enable shapes
// ================================================
`timescale 1ns/100ps

module memStageAssertions (
    input logic          clk,
    input logic          rst,
    input logic          stall,
    input logic          clr,
    input mipsPkg::memOp op,
    input logic [3:0]    laneWe,
    input logic [31:0]   instrWb,
    input logic [31:0]   pcWb,
    input logic [31:0]   memReadDataWb,
    input logic [4:0]    regWriteAddrWb,
    input logic [31:0]   regWriteDataWb
);
    import mipsPkg::*;

    logic [132:0] wbAll;
    // running count of assertion failures
    int           failCount = 0;

    // all WB state as one vector
    assign wbAll = {instrWb, pcWb, memReadDataWb, regWriteAddrWb, regWriteDataWb};

    wbClear: assert property (@(posedge clk) (rst || clr) |=> (wbAll == '0))
        else begin
            failCount++;
            $error("WB outputs not zero after rst or clr");
        end

    wbHold: assert property (@(posedge clk) (stall && !clr && !rst) |=> $stable(wbAll))
        else begin
            failCount++;
            $error("WB outputs changed during stall");
        end

    // byte store touches exactly one lane
    sbLane: assert property (@(posedge clk) disable iff (rst)
        (op == memSb && !clr) |-> $onehot(laneWe))
        else begin
            failCount++;
            $error("sb lane enable not one-hot");
        end

    shLane: assert property (@(posedge clk) disable iff (rst)
        (op == memSh && !clr) |-> (laneWe inside {4'b0011, 4'b1100}))
        else begin
            failCount++;
            $error("sh lane enable not an aligned pair");
        end

    swLane: assert property (@(posedge clk) disable iff (rst)
        (op == memSw && !clr) |-> (laneWe == 4'b1111))
        else begin
            failCount++;
            $error("sw lane enable not all lanes");
        end

    noLane: assert property (@(posedge clk) disable iff (rst)
        (clr || !(op inside {memSb, memSh, memSw})) |-> (laneWe == 4'b0000))
        else begin
            failCount++;
            $error("lane enable raised without a live store");
        end

endmodule

// File: tb/memStageTb.sv
// ================================================
// MIPS memory-stage testbench
// directed and random load/store traffic, a byte
// array reference memory and a WB output checker
// ================================================
`timescale 1ns/100ps
`include "mips_cfg.svh"

module memStageTb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_PAIRS   = 24;
    localparam int PASS_COUNT   = 8;
    // reset, reset loads, sw/lw pairs, subword, forwarding, pass-through, stall/clr, tail
    localparam int TOTAL_CYCLES = RESET_CYCLES + 4 + 2 * RAND_PAIRS + 20 + 8 + PASS_COUNT + 11 + 3;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        clr;
    logic [31:0] instrMem;
    logic [31:0] pcMem;
    logic [31:0] aluOutMem;
    logic [31:0] memWriteDataMem;
    logic [4:0]  regWriteAddrMem;
    logic [31:0] regWriteDataMem;
    logic [4:0]  regAddrWb;
    logic [31:0] regDataWb;
    logic [31:0] instrWb;
    logic [31:0] pcWb;
    logic [31:0] memReadDataWb;
    logic [4:0]  regWriteAddrWb;
    logic [31:0] regWriteDataWb;

    // little-endian byte image of data memory
    logic [7:0]  refMem [`MEM_DEPTH_WORDS*4];
    logic [31:0] expInstr;
    logic [31:0] expPc;
    logic [31:0] expRead;
    logic [4:0]  expAddr;
    logic [31:0] expData;
    logic [4:0]  fwdAddr;
    logic [31:0] fwdData;
    logic [31:0] pcCount;
    logic [5:0]  nonMemOps [4];
    string       testName;
    int          errorCount;
    logic [31:0] addr;
    logic [31:0] data;

    memStage memStage_inst (.*);

    bind memStage memStageAssertions memStageAssertionsInst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic isLoadOp(input logic [5:0] opcode);
        return opcode inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW};
    endfunction

    function automatic logic isStoreOp(input logic [5:0] opcode);
        return opcode inside {`OP_SB, `OP_SH, `OP_SW};
    endfunction

    // expected load value from the reference memory
    // non-loads see the whole addressed word
    function automatic logic [31:0] refLoad(input logic [5:0] opcode, input logic [31:0] a);
        int          base;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        base = ((a >> 2) % `MEM_DEPTH_WORDS) * 4;
        w = {refMem[base+3], refMem[base+2], refMem[base+1], refMem[base]};
        b = refMem[base + a[1:0]];
        h = {refMem[base + {a[1], 1'b1}], refMem[base + {a[1], 1'b0}]};
        case (opcode)
            `OP_LB:  return {{24{b[7]}}, b};
            `OP_LBU: return {24'h000000, b};
            `OP_LH:  return {{16{h[15]}}, h};
            `OP_LHU: return {16'h0000, h};
            default: return w;
        endcase
    endfunction

    // store with write-back forwarding on rt
    task automatic commitStore(input logic [31:0] instr, input logic [31:0] a,
                               input logic [31:0] wdata);
        int          base;
        logic [31:0] value;
        base  = ((a >> 2) % `MEM_DEPTH_WORDS) * 4;
        value = (regAddrWb == instr[20:16] && regAddrWb != 5'd0) ? regDataWb : wdata;
        case (instr[31:26])
            `OP_SW: begin
                for (int k = 0; k < 4; k++) begin
                    refMem[base+k] = value[8*k +: 8];
                end
            end
            `OP_SH: begin
                refMem[base + {a[1], 1'b0}] = value[7:0];
                refMem[base + {a[1], 1'b1}] = value[15:8];
            end
            default: refMem[base + a[1:0]] = value[7:0];
        endcase
    endtask

    task automatic checkField(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errorCount++;
            $display("error: test %s, %s expected %h actual %h",
                     testName, field, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "WB output mismatch");
        end
    endtask

    // bound concurrent assertions keep their own failure count
    task automatic checkAssertions();
        assert (memStage_inst.memStageAssertionsInst.failCount == 0) else begin
            errorCount++;
            $display("a bound assertion failed during test %s", testName);
            $display("STATUS: FAIL");
            $fatal(1, "concurrent assertion failure");
        end
    endtask

    // one instruction per cycle, driven just after the edge
    task automatic issue(input logic [5:0] opcode, input logic [4:0] rt,
                         input logic [31:0] a, input logic [31:0] wdata,
                         input logic s, input logic c);
        @(posedge clk);
        #2;
        instrMem        = {opcode, 5'($urandom), rt, 16'($urandom)};
        pcMem           = pcCount;
        pcCount         = pcCount + 32'd4;
        aluOutMem       = a;
        memWriteDataMem = wdata;
        regWriteAddrMem = 5'($urandom);
        regWriteDataMem = $urandom;
        regAddrWb       = fwdAddr;
        regDataWb       = fwdData;
        stall           = s;
        clr             = c;
    endtask

    // model the MEM/WB register at each edge, compare at the falling edge
    initial begin
        forever begin
            @(posedge clk);
            if (rst || clr) begin
                expInstr = '0;
                expPc    = '0;
                expRead  = '0;
                expAddr  = '0;
                expData  = '0;
            end else if (!stall) begin
                expInstr = instrMem;
                expPc    = pcMem;
                expRead  = refLoad(instrMem[31:26], aluOutMem);
                expAddr  = regWriteAddrMem;
                expData  = isLoadOp(instrMem[31:26]) ? expRead : regWriteDataMem;
            end
            // memory write is not held by stall
            if (rst) begin
                for (int k = 0; k < `MEM_DEPTH_WORDS * 4; k++) begin
                    refMem[k] = 8'h00;
                end
            end else if (!clr && isStoreOp(instrMem[31:26])) begin
                commitStore(instrMem, aluOutMem, memWriteDataMem);
            end
            @(negedge clk);
            checkField("instrWb", expInstr, instrWb);
            checkField("pcWb", expPc, pcWb);
            checkField("memReadDataWb", expRead, memReadDataWb);
            checkField("regWriteAddrWb", {27'd0, expAddr}, {27'd0, regWriteAddrWb});
            checkField("regWriteDataWb", expData, regWriteDataWb);
            checkAssertions();
        end
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within the expected time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(48));
        clk             = 1'b0;
        rst             = 1'b1;
        stall           = 1'b0;
        clr             = 1'b0;
        instrMem        = '0;
        pcMem           = '0;
        aluOutMem       = '0;
        memWriteDataMem = '0;
        regWriteAddrMem = '0;
        regWriteDataMem = '0;
        regAddrWb       = '0;
        regDataWb       = '0;
        fwdAddr         = '0;
        fwdData         = '0;
        pcCount         = 32'h0040_0000;
        errorCount      = 0;
        nonMemOps       = '{6'h00, 6'h08, 6'h0D, 6'h0F};
        testName        = "reset";
        for (int k = 0; k < `MEM_DEPTH_WORDS * 4; k++) begin
            refMem[k] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // cleared memory reads back zero
        for (int k = 0; k < 4; k++) begin
            issue(`OP_LW, 5'd1, $urandom, $urandom, 1'b0, 1'b0);
        end

        testName = "swLw";
        for (int k = 0; k < RAND_PAIRS; k++) begin
            addr    = $urandom;
            data    = $urandom;
            fwdAddr = 5'($urandom);
            fwdData = $urandom;
            issue(`OP_SW, 5'($urandom), addr, data, 1'b0, 1'b0);
            issue(`OP_LW, 5'($urandom), {addr[31:2], 2'($urandom)}, $urandom, 1'b0, 1'b0);
        end

        // odd lanes positive, even lanes negative
        testName = "subword";
        fwdAddr  = 5'd0;
        for (int lane = 0; lane < 4; lane++) begin
            addr = 32'h40 + lane;
            data = {24'($urandom), lane[0] ? 8'h3C + 8'(lane) : 8'hC3 + 8'(lane)};
            issue(`OP_SB, 5'd2, addr, data, 1'b0, 1'b0);
            issue(`OP_LB, 5'd3, addr, $urandom, 1'b0, 1'b0);
            issue(`OP_LBU, 5'd3, addr, $urandom, 1'b0, 1'b0);
        end
        for (int half = 0; half < 2; half++) begin
            addr = 32'h44 + 2 * half;
            data = {16'($urandom), half ? 16'h3E71 : 16'h8A5C};
            issue(`OP_SH, 5'd2, addr, data, 1'b0, 1'b0);
            issue(`OP_LH, 5'd3, addr, $urandom, 1'b0, 1'b0);
            issue(`OP_LHU, 5'd3, addr, $urandom, 1'b0, 1'b0);
        end
        issue(`OP_LW, 5'd3, 32'h40, $urandom, 1'b0, 1'b0);
        issue(`OP_LW, 5'd3, 32'h44, $urandom, 1'b0, 1'b0);

        testName = "forward";
        fwdAddr  = 5'd5;
        fwdData  = 32'h1234_ABCD;
        issue(`OP_SW, 5'd5, 32'h80, 32'hFFFF_0000, 1'b0, 1'b0);
        issue(`OP_LW, 5'd3, 32'h80, $urandom, 1'b0, 1'b0);
        // $zero never forwards
        fwdAddr = 5'd0;
        fwdData = 32'hAAAA_5555;
        issue(`OP_SW, 5'd0, 32'h84, 32'h0BAD_0BAD, 1'b0, 1'b0);
        issue(`OP_LW, 5'd3, 32'h84, $urandom, 1'b0, 1'b0);
        fwdAddr = 5'd9;
        issue(`OP_SW, 5'd7, 32'h88, 32'h7654_3210, 1'b0, 1'b0);
        issue(`OP_LW, 5'd3, 32'h88, $urandom, 1'b0, 1'b0);
        fwdAddr = 5'd12;
        fwdData = 32'h0000_00E7;
        issue(`OP_SB, 5'd12, 32'h8B, 32'h0000_0011, 1'b0, 1'b0);
        issue(`OP_LW, 5'd3, 32'h88, $urandom, 1'b0, 1'b0);

        testName = "passThrough";
        fwdAddr  = 5'd0;
        for (int k = 0; k < PASS_COUNT; k++) begin
            issue(nonMemOps[$urandom % 4], 5'($urandom), $urandom, $urandom, 1'b0, 1'b0);
        end

        // hold, flush during hold, reload, flush, flushed store
        testName = "stallClr";
        issue(6'h08, 5'd4, $urandom, $urandom, 1'b0, 1'b0);
        for (int k = 0; k < 3; k++) begin
            issue(6'h0D, 5'd4, $urandom, $urandom, 1'b1, 1'b0);
        end
        issue(6'h08, 5'd4, $urandom, $urandom, 1'b1, 1'b1);
        issue(6'h0D, 5'd4, $urandom, $urandom, 1'b0, 1'b0);
        issue(6'h08, 5'd4, $urandom, $urandom, 1'b0, 1'b1);
        issue(`OP_SW, 5'd4, 32'hC0, 32'hDEAD_BEEF, 1'b0, 1'b1);
        issue(`OP_LW, 5'd3, 32'hC0, $urandom, 1'b0, 1'b0);
        issue(`OP_SW, 5'd4, 32'hC4, 32'h5A5A_A5A5, 1'b1, 1'b0);
        issue(`OP_LW, 5'd3, 32'hC4, $urandom, 1'b0, 1'b0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        // let the last comparison finish first
        #1;
        if (errorCount == 0 && memStage_inst.memStageAssertionsInst.failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/mipsPkg.sv
design/memOpDecoder.sv
design/storeAligner.sv
design/byteBank.sv
design/loadExtractor.sv
design/memStage.sv
tb/memStage_assertions.sv
tb/memStageTb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mipsPkg.sv
      - design/memOpDecoder.sv
      - design/storeAligner.sv
      - design/byteBank.sv
      - design/loadExtractor.sv
      - design/memStage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/memStage_assertions.sv
      - tb/memStageTb.sv
